/* hw/icache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     icache_work_en,
    input  wire logic                     icache_sleep_en,
    input  wire logic                     fetch_req,
    input  wire icache_pkg::fetch_addr_t  fetch_addr,
    output logic                          fetch_gnt,
    output logic                          fetch_r_valid,
    output logic [31:0]                   fetch_r_data,
    output icache_pkg::array_cmd_t        array_cmd,
    input  wire icache_pkg::lookup_t      lookup,
    input  wire icache_pkg::way_sel_t     victim_way,
    output logic                          plru_touch,
    output logic [icache_pkg::SET_W-1:0]  plru_set,
    output icache_pkg::way_sel_t          plru_way,
    output logic                          refill_start,
    output icache_pkg::line_num_t         refill_line,
    input  wire icache_pkg::fill_word_t   fill,
    input  wire logic                     fill_done
);

    typedef enum logic [1:0] {
        S_SLEEP,
        S_IDLE,
        S_COMPARE,  // tag compare of last granted fetch
        S_MISS      // line refill in progress
    } state_t;

    state_t                   state_q, state_d;
    icache_pkg::fetch_addr_t  addr_q;        // granted fetch address
    icache_pkg::way_sel_t     victim_q;      // way being refilled
    logic                     sleep_pend_q;  // sleep seen while busy
    logic                     take_sleep;

    // sleep only from idle, nothing outstanding then
    assign take_sleep = (state_q == S_IDLE) & (icache_sleep_en | sleep_pend_q);

    assign plru_set    = addr_q.f.set;   // touch and query share the set
    assign refill_line = addr_q.l.line;

    always_comb begin
        state_d       = state_q;
        fetch_gnt     = 1'b0;
        fetch_r_valid = 1'b0;
        fetch_r_data  = lookup.rdata;
        plru_touch    = 1'b0;
        plru_way      = lookup.hit_way;
        refill_start  = 1'b0;
        array_cmd        = '0;
        array_cmd.set    = fetch_addr.f.set;   // read index of a new grant
        array_cmd.word   = fetch_addr.f.word;
        array_cmd.tag    = addr_q.f.tag;
        array_cmd.wdata  = fill.data;
        case (state_q)
            S_SLEEP: begin
                if (icache_work_en)
                    state_d = S_IDLE;
            end
            S_IDLE: begin
                if (take_sleep) begin
                    array_cmd.flush = 1'b1;  // every line invalid
                    state_d = S_SLEEP;
                end else if (fetch_req) begin
                    fetch_gnt = 1'b1;
                    state_d   = S_COMPARE;
                end
            end
            S_COMPARE: begin
                if (lookup.hit) begin
                    fetch_r_valid = 1'b1;
                    plru_touch    = 1'b1;
                    // pipeline next fetch unless a sleep is waiting
                    if (fetch_req & ~icache_sleep_en & ~sleep_pend_q)
                        fetch_gnt = 1'b1;
                    else
                        state_d = S_IDLE;
                end else begin
                    refill_start = 1'b1;
                    state_d      = S_MISS;
                end
            end
            S_MISS: begin
                array_cmd.set  = addr_q.f.set;
                array_cmd.word = fill.word;
                fetch_r_data   = fill.data;
                if (fill.valid) begin
                    array_cmd.wr_way = victim_q;
                    // critical word straight to the core
                    fetch_r_valid = (fill.word == addr_q.f.word);
                end
                if (fill_done) begin
                    array_cmd.commit = 1'b1;
                    plru_touch = 1'b1;
                    plru_way   = victim_q;
                    state_d    = S_IDLE;
                end
            end
            default: state_d = S_SLEEP;
        endcase
        array_cmd.rd = fetch_gnt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= S_SLEEP;  // asleep until work enable
            sleep_pend_q <= 1'b0;
            victim_q     <= '0;
            addr_q       <= '0;
        end else begin
            state_q <= state_d;
            if (take_sleep | (state_q == S_SLEEP))
                sleep_pend_q <= 1'b0;
            else if (icache_sleep_en)
                sleep_pend_q <= 1'b1;
            if ((state_q == S_COMPARE) & ~lookup.hit)
                victim_q <= victim_way;  // hold for the whole refill
            if (fetch_gnt)
                addr_q <= fetch_addr;
        end
    end

endmodule

`default_nettype wire

/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // address split 10 tag / 3 set / 4 word / 2 byte
    localparam int ADDR_W     = 19;
    localparam int TAG_W      = 10;
    localparam int SET_W      = 3;
    localparam int WORD_W     = 4;
    localparam int NUM_WAYS   = 4;
    localparam int NUM_SETS   = 8;
    localparam int LINE_WORDS = 16;

    typedef logic [ADDR_W-WORD_W-3:0] line_num_t;  // 64B line number
    typedef logic [NUM_WAYS-1:0]      way_sel_t;   // one-hot

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [SET_W-1:0]  set;
        logic [WORD_W-1:0] word;
        logic [1:0]        byte_off;
    } addr_fields_t;  // lookup view

    typedef struct packed {
        line_num_t         line;
        logic [WORD_W+1:0] offset;
    } line_view_t;  // refill view

    typedef union packed {
        addr_fields_t f;
        line_view_t   l;
    } fetch_addr_t;

    typedef struct packed {
        logic              rd;      // read all ways at set/word
        way_sel_t          wr_way;  // data+tag write strobe per way
        logic [SET_W-1:0]  set;
        logic [WORD_W-1:0] word;
        logic [TAG_W-1:0]  tag;     // compare tag, also tag write data
        logic [31:0]       wdata;
        logic              commit;  // set valid of wr_way at set
        logic              flush;   // drop every line
    } array_cmd_t;

    typedef struct packed {
        logic        hit;
        way_sel_t    hit_way;
        logic [31:0] rdata;
    } lookup_t;

    typedef struct packed {
        logic      req;
        line_num_t line;
    } refill_req_t;

    typedef struct packed {
        logic        gnt;
        logic        r_valid;
        logic [31:0] r_data;
    } refill_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] word;
        logic [31:0]       data;
    } fill_word_t;

endpackage

`default_nettype wire

/* hw/icache_plru.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_plru (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     touch,
    input  wire logic [icache_pkg::SET_W-1:0] set,
    input  wire icache_pkg::way_sel_t     way,
    output icache_pkg::way_sel_t          oldest
);

    // bit0 root, bit1 picks in ways 0/1, bit2 picks in ways 2/3
    // each bit points at the older side
    logic [icache_pkg::NUM_SETS-1:0][2:0] tree_q;
    logic [2:0]                           cur;
    logic [2:0]                           tree_nxt;

    assign cur = tree_q[set];

    always_comb begin
        tree_nxt = cur;
        if (way[0] | way[1]) begin
            tree_nxt[0] = 1'b1;    // older side now right pair
            tree_nxt[1] = way[0];  // sibling of touched way
        end else begin
            tree_nxt[0] = 1'b0;
            tree_nxt[2] = way[2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tree_q <= '0;
        else if (touch)
            tree_q[set] <= tree_nxt;
    end

    // walk the tree, comb from current bits
    always_comb begin
        oldest = '0;
        if (!cur[0])
            oldest[cur[1]] = 1'b1;
        else
            oldest[{1'b1, cur[2]}] = 1'b1;
    end

endmodule

`default_nettype wire

/* hw/icache_refill.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_refill (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start,
    input  wire icache_pkg::line_num_t    line,
    output icache_pkg::refill_req_t       l2_req,
    input  wire icache_pkg::refill_rsp_t  l2_rsp,
    output icache_pkg::fill_word_t        fill,
    output logic                          done,
    output logic                          refill_done
);

    localparam int LAST_BEAT = icache_pkg::LINE_WORDS - 1;

    logic                          req_q;     // held until gnt
    logic                          active_q;  // beats expected
    icache_pkg::line_num_t         line_q;
    logic [icache_pkg::WORD_W-1:0] beat_q;    // index of next beat
    logic                          beat_ok;
    logic                          last_beat;

    assign beat_ok   = active_q & l2_rsp.r_valid;
    assign last_beat = beat_q == LAST_BEAT[icache_pkg::WORD_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q    <= 1'b0;
            active_q <= 1'b0;
            beat_q   <= '0;
        end else begin
            if (start)
                req_q <= 1'b1;
            else if (l2_rsp.gnt)
                req_q <= 1'b0;  // drop after handshake
            if (req_q & l2_rsp.gnt) begin
                active_q <= 1'b1;
                beat_q   <= '0;   // line comes back from word 0
            end else if (beat_ok) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat)
                    active_q <= 1'b0;
            end
        end
    end

    // line number latched once per miss
    always_ff @(posedge clk) begin
        if (start)
            line_q <= line;
    end

    assign l2_req.req  = req_q;
    assign l2_req.line = line_q;

    // fill word straight from the beat
    assign fill.valid = beat_ok;
    assign fill.word  = beat_q;
    assign fill.data  = l2_rsp.r_data;

    assign done        = beat_ok & last_beat;
    assign refill_done = done;  // same pulse seen outside

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_top (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    // core fetch port
    input  wire logic                     fetch_req,
    output logic                          fetch_gnt,
    input  wire icache_pkg::fetch_addr_t  fetch_addr,
    output logic                          fetch_r_valid,
    output logic [31:0]                   fetch_r_data,
    // level-2 refill port
    output icache_pkg::refill_req_t       l2_req,
    input  wire icache_pkg::refill_rsp_t  l2_rsp,
    output logic                          refill_done,
    input  wire logic                     icache_work_en,
    input  wire logic                     icache_sleep_en
);

    icache_pkg::array_cmd_t         array_cmd;
    icache_pkg::lookup_t            lookup;
    icache_pkg::way_sel_t           victim_way;
    icache_pkg::way_sel_t           plru_way;
    icache_pkg::way_sel_t           plru_oldest;
    logic                           plru_touch;
    logic [icache_pkg::SET_W-1:0]   plru_set;
    logic                           refill_start;
    icache_pkg::line_num_t          refill_line;
    icache_pkg::fill_word_t         fill;
    logic                           fill_done;

    icache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .icache_work_en  (icache_work_en),
        .icache_sleep_en (icache_sleep_en),
        .fetch_req       (fetch_req),
        .fetch_addr      (fetch_addr),
        .fetch_gnt       (fetch_gnt),
        .fetch_r_valid   (fetch_r_valid),
        .fetch_r_data    (fetch_r_data),
        .array_cmd       (array_cmd),
        .lookup          (lookup),
        .victim_way      (victim_way),
        .plru_touch      (plru_touch),
        .plru_set        (plru_set),
        .plru_way        (plru_way),
        .refill_start    (refill_start),
        .refill_line     (refill_line),
        .fill            (fill),
        .fill_done       (fill_done)
    );

    icache_ways u_ways (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (array_cmd),
        .plru_oldest (plru_oldest),
        .lookup      (lookup),
        .victim_way  (victim_way)
    );

    icache_plru u_plru (
        .clk    (clk),
        .rst_n  (rst_n),
        .touch  (plru_touch),
        .set    (plru_set),
        .way    (plru_way),
        .oldest (plru_oldest)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (refill_start),
        .line        (refill_line),
        .l2_req      (l2_req),
        .l2_rsp      (l2_rsp),
        .fill        (fill),
        .done        (fill_done),
        .refill_done (refill_done)
    );

endmodule

`default_nettype wire

/* hw/icache_ways.sv */
`timescale 1ns/10ps
`default_nettype none

module icache_ways (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire icache_pkg::array_cmd_t  cmd,
    input  wire icache_pkg::way_sel_t    plru_oldest,
    output icache_pkg::lookup_t          lookup,
    output icache_pkg::way_sel_t         victim_way
);

    localparam int DEPTH = icache_pkg::NUM_SETS * icache_pkg::LINE_WORDS;  // words per way

    logic [icache_pkg::TAG_W-1:0]  tag_mem  [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    logic [31:0]                   data_mem [icache_pkg::NUM_WAYS][DEPTH];
    logic [icache_pkg::TAG_W-1:0]  tag_rd   [icache_pkg::NUM_WAYS];
    logic [31:0]                   data_rd  [icache_pkg::NUM_WAYS];

    logic [icache_pkg::NUM_SETS-1:0][icache_pkg::NUM_WAYS-1:0] valid_q;
    logic [icache_pkg::SET_W-1:0]  rd_set_q;   // set of the read in flight
    icache_pkg::way_sel_t          set_valid;
    icache_pkg::way_sel_t          hit_way;
    icache_pkg::way_sel_t          first_free;

    // behavioral single-port arrays, one per way
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (cmd.wr_way[w]) begin
                data_mem[w][{cmd.set, cmd.word}] <= cmd.wdata;
                tag_mem[w][cmd.set]              <= cmd.tag;  // rewritten each beat
            end
            if (cmd.rd) begin
                data_rd[w] <= data_mem[w][{cmd.set, cmd.word}];
                tag_rd[w]  <= tag_mem[w][cmd.set];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rd_set_q <= '0;
        end else begin
            if (cmd.flush)
                valid_q <= '0;
            else if (cmd.commit)
                valid_q[cmd.set] <= valid_q[cmd.set] | cmd.wr_way;
            if (cmd.rd)
                rd_set_q <= cmd.set;
        end
    end

    assign set_valid = valid_q[rd_set_q];

    // tag compare one cycle after the read
    always_comb begin
        hit_way      = '0;
        lookup.rdata = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = set_valid[w] & (tag_rd[w] == cmd.tag);
            if (hit_way[w])
                lookup.rdata = lookup.rdata | data_rd[w];
        end
        lookup.hit     = |hit_way;
        lookup.hit_way = hit_way;
    end

    // lowest invalid way wins, plru only once the set is full
    always_comb begin
        first_free = '0;
        for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                first_free    = '0;
                first_free[w] = 1'b1;
            end
        end
        victim_way = (&set_valid) ? plru_oldest : first_free;
    end

endmodule

`default_nettype wire

/* icache_top.f */
hw/icache_pkg.sv
hw/icache_plru.sv
hw/icache_ways.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_top.sv
testbench/tb_l2_model.sv
testbench/tb_icache.sv

/* testbench/tb_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_icache;

    localparam int NUM_TESTS   = 5;
    localparam int MAX_FETCHES = 12;  // longest test has 11
    localparam int TIMEOUT     = NUM_TESTS * MAX_FETCHES * (icache_pkg::LINE_WORDS * 4 + 10);

    logic                    clk;
    logic                    rst_n;
    logic                    fetch_req;
    logic                    fetch_gnt;
    icache_pkg::fetch_addr_t fetch_addr;
    logic                    fetch_r_valid;
    logic [31:0]             fetch_r_data;
    icache_pkg::refill_req_t l2_req;
    icache_pkg::refill_rsp_t l2_rsp;
    logic                    refill_done;
    logic                    work_en;
    logic                    sleep_en;

    icache_pkg::fetch_addr_t pend_q[$];  // granted with answer still due
    logic [31:0]             exp_data;   // pattern of the oldest pending fetch
    icache_pkg::line_num_t   exp_line;
    int                      pend_cnt;
    logic                    awake;       // work enable given once
    logic                    expect_hit;  // current fetch should hit
    string                   cur_test;
    int                      gnt_cnt;
    int                      resp_cnt;
    int                      refill_cnt;
    int                      done_cnt;
    int                      fetch_cnt;
    int                      err_cnt;
    int                      cycle_cnt;
    int                      tests_failed;
    int                      t_refill;  // counts at test start
    int                      t_done;
    int                      t_resp;
    int                      t_fetch;
    int                      t_err;
    logic [18:0]             line_a;

    always #5 clk = ~clk;

    icache_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req       (fetch_req),
        .fetch_gnt       (fetch_gnt),
        .fetch_addr      (fetch_addr),
        .fetch_r_valid   (fetch_r_valid),
        .fetch_r_data    (fetch_r_data),
        .l2_req          (l2_req),
        .l2_rsp          (l2_rsp),
        .refill_done     (refill_done),
        .icache_work_en  (work_en),
        .icache_sleep_en (sleep_en)
    );

    tb_l2_model u_l2 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (l2_req),
        .rsp   (l2_rsp)
    );

    // 13'h1ace on top of the word's byte address
    function automatic logic [31:0] word_pattern(input logic [18:0] a);
        return {13'h1ace, a[18:2], 2'b00};
    endfunction

    function automatic icache_pkg::line_num_t line_number(input logic [18:0] a);
        return a[18:6];  // 64-byte lines
    endfunction

    function automatic logic [18:0] make_addr(input logic [9:0] tag, input logic [2:0] set,
                                              input logic [3:0] word);
        return {tag, set, word, 2'b00};
    endfunction

    // scoreboard and counters sample pre-edge values like any flop
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT);
            $display("Test failures found");
            $finish;
        end
        if (fetch_req && fetch_gnt) begin
            pend_q.push_back(fetch_addr);
            gnt_cnt++;
        end
        if (fetch_r_valid) begin
            resp_cnt++;
            if (pend_q.size() != 0)
                void'(pend_q.pop_front());  // answers come in grant order
        end
        if (l2_req.req && l2_rsp.gnt)
            refill_cnt++;
        if (refill_done)
            done_cnt++;
        pend_cnt = pend_q.size();
        if (pend_cnt != 0) begin
            exp_data = word_pattern(pend_q[0]);
            exp_line = line_number(pend_q[0]);
        end
    end

    sleep_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !awake |-> !(fetch_gnt || fetch_r_valid || l2_req.req || refill_done))
    else begin
        $display("%s: cache active before work enable", cur_test);
        err_cnt++;
    end

    data_match: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid |-> fetch_r_data == exp_data)
    else begin
        $display("MISMATCH %s: fetch data expected %h actual %h",
                 cur_test, $sampled(exp_data), $sampled(fetch_r_data));
        err_cnt++;
    end

    resp_owed: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_r_valid |-> pend_cnt != 0)
    else begin
        $display("%s: response given with no fetch outstanding", cur_test);
        err_cnt++;
    end

    hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_req && fetch_gnt && expect_hit) |=> fetch_r_valid)
    else begin
        $display("%s: hit not answered one cycle after its grant", cur_test);
        err_cnt++;
    end

    refill_line: assert property (@(posedge clk) disable iff (!rst_n)
        (l2_req.req && l2_rsp.gnt) |-> l2_req.line == exp_line)
    else begin
        $display("MISMATCH %s: refill line expected %h actual %h",
                 cur_test, $sampled(exp_line), $sampled(l2_req.line));
        err_cnt++;
    end

    task automatic begin_test(input string name);
        cur_test = name;
        t_refill = refill_cnt;
        t_done   = done_cnt;
        t_resp   = resp_cnt;
        t_fetch  = fetch_cnt;
        t_err    = err_cnt;
    endtask

    // single fetch, then wait for its answer and the end of any refill
    task automatic fetch_one(input logic [18:0] a, input logic hit);
        @(negedge clk);
        fetch_req  = 1'b1;
        fetch_addr = a;
        expect_hit = hit;
        @(posedge clk);
        while (!fetch_gnt)
            @(posedge clk);
        fetch_cnt++;
        @(negedge clk);
        fetch_req  = 1'b0;
        expect_hit = 1'b0;
        while (resp_cnt < gnt_cnt || done_cnt < refill_cnt)
            @(negedge clk);
    endtask

    // consecutive words with req held so hits overlap their answers
    task automatic fetch_burst(input logic [18:0] base, input int n);
        @(negedge clk);
        fetch_req  = 1'b1;
        fetch_addr = base;
        expect_hit = 1'b1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            while (!fetch_gnt)
                @(posedge clk);
            fetch_cnt++;
            @(negedge clk);
            if (i == n - 1) begin
                fetch_req  = 1'b0;
                expect_hit = 1'b0;
            end else begin
                fetch_addr = base + 19'(4 * (i + 1));
            end
        end
        while (resp_cnt < gnt_cnt)
            @(negedge clk);
    endtask

    task automatic end_test(input int exp_refills);
        int refills;
        int dones;
        int resps;
        int fetches;
        while (resp_cnt < gnt_cnt || done_cnt < refill_cnt)
            @(negedge clk);
        refills = refill_cnt - t_refill;
        dones   = done_cnt - t_done;
        resps   = resp_cnt - t_resp;
        fetches = fetch_cnt - t_fetch;
        refill_count: assert (refills == exp_refills) else begin
            $display("MISMATCH %s: refill requests expected %0d actual %0d",
                     cur_test, exp_refills, refills);
            err_cnt++;
        end
        done_count: assert (dones == exp_refills) else begin
            $display("MISMATCH %s: refill_done pulses expected %0d actual %0d",
                     cur_test, exp_refills, dones);
            err_cnt++;
        end
        resp_count: assert (resps == fetches) else begin
            $display("MISMATCH %s: responses expected %0d actual %0d", cur_test, fetches, resps);
            err_cnt++;
        end
        if (err_cnt == t_err) begin
            $display("test %s: ok, %0d fetches, %0d refills", cur_test, fetches, refills);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", cur_test, err_cnt - t_err);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_req    = 1'b0;
        fetch_addr   = '0;
        work_en      = 1'b0;
        sleep_en     = 1'b0;
        awake        = 1'b0;
        expect_hit   = 1'b0;
        exp_data     = '0;
        exp_line     = '0;
        pend_cnt     = 0;
        gnt_cnt      = 0;
        resp_cnt     = 0;
        refill_cnt   = 0;
        done_cnt     = 0;
        fetch_cnt    = 0;
        err_cnt      = 0;
        cycle_cnt    = 0;
        tests_failed = 0;
        line_a       = make_addr(10'h055, 3'd2, 4'd9);

        // request held through reset and sleep with no answer allowed
        begin_test("reset_state");
        fetch_req  = 1'b1;
        fetch_addr = make_addr(10'h3c1, 3'd0, 4'd0);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (20) @(negedge clk);
        fetch_req = 1'b0;
        work_en   = 1'b1;
        awake     = 1'b1;
        end_test(0);

        begin_test("miss_forward");
        fetch_one(line_a, 1'b0);  // word 9 forwarded mid-line
        end_test(1);

        begin_test("hits");
        fetch_one(make_addr(10'h055, 3'd2, 4'd0), 1'b1);
        fetch_one(make_addr(10'h055, 3'd2, 4'd15), 1'b1);
        fetch_one(line_a, 1'b1);
        fetch_burst(make_addr(10'h055, 3'd2, 4'd4), 8);
        end_test(0);

        // lines A..E in set 5 where E evicts A and A evicts another
        begin_test("replacement");
        for (int i = 0; i < 5; i++)
            fetch_one(make_addr(10'h100 + 10'(i), 3'd5, 4'(i)), 1'b0);
        for (int i = 1; i < 5; i++)
            fetch_one(make_addr(10'h100 + 10'(i), 3'd5, 4'(i + 8)), 1'b1);
        fetch_one(make_addr(10'h100, 3'd5, 4'd7), 1'b0);
        end_test(6);

        begin_test("sleep_flush");
        fetch_one(line_a, 1'b1);
        @(negedge clk);
        work_en  = 1'b0;
        sleep_en = 1'b1;
        repeat (2) @(negedge clk);
        sleep_en = 1'b0;
        repeat (4) @(negedge clk);
        work_en = 1'b1;
        fetch_one(line_a, 1'b0);  // flushed so refetched from level 2
        end_test(1);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_l2_model.sv */
`timescale 1ns/10ps
`default_nettype none

// level-2 responder, one line per request, beats in word order
module tb_l2_model (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire icache_pkg::refill_req_t  req,
    output icache_pkg::refill_rsp_t       rsp
);

    logic [31:0]           lfsr;
    logic [1:0]            gnt_delay;  // 0..3 cycles
    logic                  gap;        // idle cycle before a beat
    icache_pkg::line_num_t line;

    // galois form, shift right and fold the feedback mask in
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per random bit
    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    initial begin
        lfsr = 32'h16800db2;
        rsp  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && req.req) begin
                line = req.line;  // held by the cache until gnt
                take_bit(gnt_delay[0]);
                take_bit(gnt_delay[1]);
                repeat (gnt_delay) @(negedge clk);
                rsp.gnt = 1'b1;
                @(negedge clk);
                rsp.gnt = 1'b0;
                for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
                    take_bit(gap);
                    if (gap)
                        @(negedge clk);
                    rsp.r_valid = 1'b1;
                    // pattern sits above the word's byte address
                    rsp.r_data  = {13'h1ace, line, 4'(w), 2'b00};
                    @(negedge clk);
                    rsp.r_valid = 1'b0;
                    rsp.r_data  = '0;
                end
            end
        end
    end

endmodule

`default_nettype wire
